// File: filelist.f
+incdir+include
rtl/clock_field_pkg.sv
rtl/screen_layout_pkg.sv
rtl/digit_loader.sv
rtl/field_slot.sv
rtl/glyph_addresser.sv
rtl/edit_cursor.sv
rtl/clock_display_top.sv
sim/clock_display_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f filelist.f \
    --top-module clock_display_tb -Mdir obj_dir -o clock_display_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/clock_display_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: include/clock_display_tests.svh
`ifndef CLOCK_DISPLAY_TESTS_SVH
`define CLOCK_DISPLAY_TESTS_SVH

task automatic check_addr(input string name, input logic [7:0] expected,
                          input logic [7:0] actual);
    checks++;
    if (expected !== actual) begin
        errors++;
        $display("[ERROR] %s font_addr: expected 'h%02h, actual 'h%02h", name, expected, actual);
    end
endtask

task automatic check_cursor(input string name, input logic [8:0] expected,
                            input logic [8:0] actual);
    checks++;
    if (expected !== actual) begin
        errors++;
        $display("[ERROR] %s cursor: expected 'b%09b, actual 'b%09b", name, expected, actual);
    end
endtask

// one new beam goes in per clock and its outputs are compared two clocks later
task automatic step_beam(input string name, input beam_pos_t b, input edit_ctrl_t e);
    @(posedge reloj);
    beam <= b;
    edit <= e;
    exp_addr_q.push_back(model_addr(b));
    exp_cursor_q.push_back(model_cursor(b, e));
    @(negedge reloj);
    if (exp_addr_q.size() > 2) begin
        check_addr(name, exp_addr_q.pop_front(), font_addr);
        check_cursor(name, exp_cursor_q.pop_front(), cursor);
    end
endtask

task automatic drain_beam(input string name);
    while (exp_addr_q.size() > 0) begin
        @(posedge reloj);
        @(negedge reloj);
        check_addr(name, exp_addr_q.pop_front(), font_addr);
        check_cursor(name, exp_cursor_q.pop_front(), cursor);
    end
endtask

task automatic sweep_row(input string name, input logic [5:0] row, input int pix_step,
                         input edit_ctrl_t e);
    beam_pos_t b;
    for (int col = 0; col < 128; col++) begin
        for (int pix = 0; pix < 16; pix += pix_step) begin
            b.char_row  = row;
            b.char_col  = 7'(col);
            b.pixel_row = 4'(pix);
            step_beam(name, b, e);
        end
    end
    drain_beam(name);
endtask

task automatic host_write(input logic [3:0] code, input logic [7:0] data);
    int s;
    s = slot_of_code(code);
    @(posedge reloj);
    wr_strobe <= 1'b1;
    wr_field  <= field_code_t'(code);
    wr_data   <= data;
    if (s >= 0) begin
        model_tens[s]  = data[7:4];
        model_units[s] = data[3:0];
    end
endtask

task automatic end_writes();
    @(posedge reloj);
    wr_strobe <= 1'b0;
endtask

// holds the beam still until the address settles on the expected value
task automatic wait_for_addr(input string name, input beam_pos_t b, input logic [7:0] expected);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    @(posedge reloj);
    beam <= b;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
        @(negedge reloj);
        seen = (font_addr === expected);
        cycles++;
    end
    if (!seen) begin
        errors++;
        $display("%s: timed out waiting for the font address to settle", name);
    end
endtask

task automatic test_after_reset();
    beam_pos_t b;
    b = '{char_row: 6'd12, char_col: 7'd10, pixel_row: 4'd0};
    wait_for_addr("after reset", b, 8'hA0);
    sweep_row("after reset", 6'd12, 1, '0);
    sweep_row("after reset", 6'd17, 1, '0);
endtask

task automatic test_writes();
    int        order [9] = '{5, 4, 3, 8, 7, 6, 0, 1, 2};
    beam_pos_t b;
    // all nine fields in one back-to-back burst
    for (int i = 0; i < 9; i++) begin
        host_write(4'(order[i]), {4'($urandom_range(9, 0)), 4'($urandom_range(9, 0))});
    end
    end_writes();
    b = '{char_row: 6'd17, char_col: 7'd54, pixel_row: 4'd7};
    wait_for_addr("writes", b, model_addr(b));
    sweep_row("writes", 6'd12, 5, '0);
    sweep_row("writes", 6'd17, 5, '0);
    // a shorter burst over a few fields again
    for (int i = 0; i < 4; i++) begin
        host_write(4'($urandom_range(8, 0)), {4'($urandom_range(9, 0)), 4'($urandom_range(9, 0))});
    end
    end_writes();
    wait_for_addr("writes", b, model_addr(b));
    sweep_row("writes", 6'd12, 3, '0);
    sweep_row("writes", 6'd17, 3, '0);
endtask

task automatic test_fixed_places();
    beam_pos_t b;
    b = '{char_row: 6'd17, char_col: 7'd48, pixel_row: 4'd3};
    wait_for_addr("year prefix", b, 8'h23);
    check_addr("year prefix", 8'h23, font_addr);
    b = '{char_row: 6'd17, char_col: 7'd51, pixel_row: 4'd9};
    wait_for_addr("year prefix", b, 8'hA9);
    check_addr("year prefix", 8'hA9, font_addr);
    b = '{char_row: 6'd17, char_col: 7'd40, pixel_row: 4'd9};
    wait_for_addr("gap column", b, 8'h00);
    check_addr("gap column", 8'h00, font_addr);
    sweep_row("outside bands", 6'd0, 8, '0);
    sweep_row("outside bands", 6'd11, 8, '0);
    sweep_row("outside bands", 6'd13, 8, '0);
    sweep_row("outside bands", 6'd16, 8, '0);
    sweep_row("outside bands", 6'd18, 8, '0);
    sweep_row("outside bands", 6'd63, 8, '0);
endtask

task automatic test_bad_writes();
    beam_pos_t b;
    host_write(4'd5, 8'hA7);
    host_write(4'd3, 8'h0F);
    host_write(4'd2, 8'hCB);
    end_writes();
    b = '{char_row: 6'd12, char_col: 7'd10, pixel_row: 4'd4};
    wait_for_addr("non-BCD digits", b, 8'h04);
    sweep_row("non-BCD digits", 6'd12, 5, '0);
    sweep_row("non-BCD digits", 6'd17, 5, '0);
    // unused field codes must leave every slot alone
    host_write(4'd12, 8'h55);
    host_write(4'd15, 8'h99);
    host_write(4'd9, 8'h11);
    end_writes();
    wait_for_addr("unused codes", b, 8'h04);
    sweep_row("unused codes", 6'd12, 5, '0);
    sweep_row("unused codes", 6'd17, 5, '0);
endtask

task automatic test_edit_cursor();
    edit_ctrl_t e;
    for (int group = 0; group < 3; group++) begin
        for (int en = 0; en < 2; en++) begin
            for (int ptr = 0; ptr < 4; ptr++) begin
                e = '0;
                case (group)
                    0: begin
                        e.time_en  = 1'(en);
                        e.time_ptr = 2'(ptr);
                    end
                    1: begin
                        e.chrono_en  = 1'(en);
                        e.chrono_ptr = 2'(ptr);
                    end
                    default: begin
                        e.date_en  = 1'(en);
                        e.date_ptr = 2'(ptr);
                    end
                endcase
                sweep_row("edit cursor", 6'd12, 16, e);
                sweep_row("edit cursor", 6'd17, 16, e);
            end
        end
    end
    // all three groups enabled at once with random pointers
    for (int i = 0; i < 4; i++) begin
        e = '{time_en: 1'b1, date_en: 1'b1, chrono_en: 1'b1,
              time_ptr: 2'($urandom_range(3, 0)), date_ptr: 2'($urandom_range(3, 0)),
              chrono_ptr: 2'($urandom_range(3, 0))};
        sweep_row("edit cursor", 6'd12, 16, e);
        sweep_row("edit cursor", 6'd17, 16, e);
    end
endtask

`endif

// File: sim/clock_display_tb.sv
module clock_display_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import clock_field_pkg::*;
    import screen_layout_pkg::*;

    localparam int TIMEOUT_CYCLES = 16;

    // left column of each field's tens digit in slot order
    localparam int LEFT_COL [9] = '{10, 16, 22, 66, 72, 78, 34, 42, 52};
    localparam int PREFIX_COL   = 48;

    logic        reloj = 1'b0;
    logic        resetM;
    logic        wr_strobe;
    field_code_t wr_field;
    logic [7:0]  wr_data;
    beam_pos_t   beam;
    edit_ctrl_t  edit;
    font_addr_t  font_addr;
    logic [8:0]  cursor;

    int errors = 0;
    int checks = 0;

    // digits the display should hold in slot order
    logic [3:0] model_tens [9];
    logic [3:0] model_units [9];

    // expected outputs for beams still in the two-stage pipeline
    logic [7:0] exp_addr_q [$];
    logic [8:0] exp_cursor_q [$];

    always #50 reloj = ~reloj;

    clock_display_top clock_display_top_i (
        .reloj     (reloj),
        .resetM    (resetM),
        .wr_strobe (wr_strobe),
        .wr_field  (wr_field),
        .wr_data   (wr_data),
        .beam      (beam),
        .edit      (edit),
        .font_addr (font_addr),
        .cursor    (cursor)
    );

    function automatic logic [3:0] glyph_of(input logic [3:0] d);
        if (d == 4'd0) begin
            return 4'd10;
        end else if (d <= 4'd9) begin
            return d;
        end
        return 4'd0;
    endfunction

    // maps a host field code to its display slot and gives -1 for codes the display does not use
    function automatic int slot_of_code(input logic [3:0] code);
        case (code)
            4'd5:    return 0;
            4'd4:    return 1;
            4'd3:    return 2;
            4'd8:    return 3;
            4'd7:    return 4;
            4'd6:    return 5;
            4'd0:    return 6;
            4'd1:    return 7;
            4'd2:    return 8;
            default: return -1;
        endcase
    endfunction

    function automatic logic [7:0] model_addr(input beam_pos_t b);
        int         col;
        int         first;
        int         last;
        logic       found;
        logic [3:0] g;
        col   = int'(b.char_col);
        found = 1'b0;
        g     = 4'd0;
        if (b.char_row == 6'd12 || b.char_row == 6'd17) begin
            first = (b.char_row == 6'd12) ? 0 : 6;
            last  = (b.char_row == 6'd12) ? 5 : 8;
            for (int s = first; s <= last; s++) begin
                if (col >= LEFT_COL[s] && col < LEFT_COL[s] + 2) begin
                    g     = glyph_of(model_tens[s]);
                    found = 1'b1;
                end
                if (col >= LEFT_COL[s] + 2 && col < LEFT_COL[s] + 4) begin
                    g     = glyph_of(model_units[s]);
                    found = 1'b1;
                end
            end
            // the century is always drawn as 20
            if (b.char_row == 6'd17 && col >= PREFIX_COL && col < PREFIX_COL + 2) begin
                g     = 4'd2;
                found = 1'b1;
            end
            if (b.char_row == 6'd17 && col >= PREFIX_COL + 2 && col < PREFIX_COL + 4) begin
                g     = 4'd10;
                found = 1'b1;
            end
        end
        return found ? {g, b.pixel_row} : 8'h00;
    endfunction

    function automatic logic [8:0] model_cursor(input beam_pos_t b, input edit_ctrl_t e);
        logic [8:0] sel;
        logic [8:0] mask;
        logic [5:0] row;
        int         col;
        col    = int'(b.char_col);
        mask   = 9'd0;
        sel[0] = e.time_en && (e.time_ptr == 2'd2);
        sel[1] = e.time_en && (e.time_ptr == 2'd1);
        sel[2] = e.time_en && (e.time_ptr == 2'd0);
        sel[3] = e.chrono_en && (e.chrono_ptr == 2'd2);
        sel[4] = e.chrono_en && (e.chrono_ptr == 2'd1);
        sel[5] = e.chrono_en && (e.chrono_ptr == 2'd0);
        sel[6] = e.date_en && (e.date_ptr == 2'd0);
        sel[7] = e.date_en && (e.date_ptr == 2'd1);
        sel[8] = e.date_en && (e.date_ptr == 2'd2);
        for (int s = 0; s < 9; s++) begin
            row = (s < 6) ? 6'd12 : 6'd17;
            if (sel[s] && b.char_row == row && col >= LEFT_COL[s] && col < LEFT_COL[s] + 4) begin
                mask[8 - s] = 1'b1;
            end
        end
        return mask;
    endfunction

    `include "clock_display_tests.svh"

    initial begin
        void'($urandom(33));
        resetM    <= 1'b1;
        wr_strobe <= 1'b0;
        wr_field  <= FIELD_DAY;
        wr_data   <= 8'h00;
        beam      <= '0;
        edit      <= '0;
        for (int s = 0; s < 9; s++) begin
            model_tens[s]  = 4'd0;
            model_units[s] = 4'd0;
        end
        repeat (3) @(posedge reloj);
        resetM <= 1'b0;

        test_after_reset();
        test_writes();
        test_fixed_places();
        test_bad_writes();
        test_edit_cursor();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // the whole run takes a few milliseconds of simulated time
    initial begin
        #20_000_000;
        $display("run exceeded its time limit");
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: rtl/clock_display_top.sv
module clock_display_top (
    input  logic                                   reloj,
    input  logic                                   resetM,
    input  logic                                   wr_strobe,
    input  clock_field_pkg::field_code_t           wr_field,
    input  logic [7:0]                             wr_data,
    input  screen_layout_pkg::beam_pos_t           beam,
    input  screen_layout_pkg::edit_ctrl_t          edit,
    output screen_layout_pkg::font_addr_t          font_addr,
    output logic [clock_field_pkg::NUM_FIELDS-1:0] cursor
);
    import clock_field_pkg::*;

    digit_write_t                   wr_req;
    logic [NUM_FIELDS-1:0]          load_en;
    digit_pair_t                    digits_q;
    field_glyphs_t [NUM_FIELDS-1:0] slot_glyphs;

    // tens digit in the high nibble of the host byte
    assign wr_req = '{field: wr_field, tens: wr_data[7:4], units: wr_data[3:0]};

    digit_loader digit_loader_i (
        .reloj     (reloj),
        .resetM    (resetM),
        .wr_strobe (wr_strobe),
        .wr_req    (wr_req),
        .load_en   (load_en),
        .digits_q  (digits_q)
    );

    for (genvar i = 0; i < NUM_FIELDS; i++) begin : g_slot
        field_slot field_slot_i (
            .reloj  (reloj),
            .resetM (resetM),
            .load   (load_en[i]),
            .digits (digits_q),
            .glyphs (slot_glyphs[i])
        );
    end

    glyph_addresser glyph_addresser_i (
        .reloj     (reloj),
        .resetM    (resetM),
        .beam      (beam),
        .fields    (slot_glyphs),
        .font_addr (font_addr)
    );

    edit_cursor edit_cursor_i (
        .reloj  (reloj),
        .resetM (resetM),
        .beam   (beam),
        .edit   (edit),
        .cursor (cursor)
    );

endmodule

// File: rtl/edit_cursor.sv
module edit_cursor (
    input  logic                                   reloj,
    input  logic                                   resetM,
    input  screen_layout_pkg::beam_pos_t           beam,
    input  screen_layout_pkg::edit_ctrl_t          edit,
    output logic [clock_field_pkg::NUM_FIELDS-1:0] cursor
);
    import clock_field_pkg::*;
    import screen_layout_pkg::*;

    beam_pos_t             beam_q;
    edit_ctrl_t            edit_q;
    logic [NUM_FIELDS-1:0] selected;
    logic [NUM_FIELDS-1:0] cursor_next;

    // the cursor spans both digits of a field
    function automatic logic on_field(input char_col_t col, input char_col_t left);
        return (col >= left) && (col < left + 2 * DIGIT_COLS);
    endfunction

    always_ff @(posedge reloj) begin
        beam_q <= beam;
        edit_q <= edit;
    end

    // time and stopwatch count the pointer down from hour, the date counts it up from day
    assign selected[SLOT_HOUR]          = edit_q.time_en && (edit_q.time_ptr == 2'd2);
    assign selected[SLOT_MINUTE]        = edit_q.time_en && (edit_q.time_ptr == 2'd1);
    assign selected[SLOT_SECOND]        = edit_q.time_en && (edit_q.time_ptr == 2'd0);
    assign selected[SLOT_CHRONO_HOUR]   = edit_q.chrono_en && (edit_q.chrono_ptr == 2'd2);
    assign selected[SLOT_CHRONO_MINUTE] = edit_q.chrono_en && (edit_q.chrono_ptr == 2'd1);
    assign selected[SLOT_CHRONO_SECOND] = edit_q.chrono_en && (edit_q.chrono_ptr == 2'd0);
    assign selected[SLOT_DAY]           = edit_q.date_en && (edit_q.date_ptr == 2'd0);
    assign selected[SLOT_MONTH]         = edit_q.date_en && (edit_q.date_ptr == 2'd1);
    assign selected[SLOT_YEAR]          = edit_q.date_en && (edit_q.date_ptr == 2'd2);

    // mask is in slot order with the hour field in the top bit
    always_comb begin
        cursor_next = '0;
        for (int s = 0; s < NUM_FIELDS; s++) begin
            if (selected[s] && on_field(beam_q.char_col, FIELD_COL[s]) &&
                (beam_q.char_row == ((s < int'(SLOT_DAY)) ? ROW_TIME : ROW_DATE))) begin
                cursor_next[NUM_FIELDS-1-s] = 1'b1;
            end
        end
    end

    always_ff @(posedge reloj) begin
        if (resetM) begin
            cursor <= '0;
        end else begin
            cursor <= cursor_next;
        end
    end

    // the beam can only sit on one field at a time
    a_cursor_onehot: assert property (
        @(posedge reloj) disable iff (resetM)
        $onehot0(cursor)
    );

endmodule

// File: rtl/glyph_addresser.sv
module glyph_addresser (
    input  logic                                                    reloj,
    input  logic                                                    resetM,
    input  screen_layout_pkg::beam_pos_t                            beam,
    input  clock_field_pkg::field_glyphs_t [clock_field_pkg::NUM_FIELDS-1:0] fields,
    output screen_layout_pkg::font_addr_t                           font_addr
);
    import clock_field_pkg::*;
    import screen_layout_pkg::*;

    // the year always reads 20xx
    localparam glyph_t PREFIX_TENS  = 4'd2;
    localparam glyph_t PREFIX_UNITS = GLYPH_ZERO;

    beam_pos_t beam_q;
    glyph_t    glyph_sel;
    logic      on_digit;

    function automatic logic in_cell(input char_col_t col, input char_col_t left);
        return (col >= left) && (col < left + DIGIT_COLS);
    endfunction

    // stage 1 holds the beam position
    always_ff @(posedge reloj) begin
        beam_q <= beam;
    end

    always_comb begin
        glyph_sel = GLYPH_BLANK;
        on_digit  = 1'b0;
        if (beam_q.char_row == ROW_TIME) begin
            for (int s = int'(SLOT_HOUR); s <= int'(SLOT_CHRONO_SECOND); s++) begin
                if (in_cell(beam_q.char_col, FIELD_COL[s])) begin
                    glyph_sel = fields[s].tens_glyph;
                    on_digit  = 1'b1;
                end
                if (in_cell(beam_q.char_col, FIELD_COL[s] + DIGIT_COLS)) begin
                    glyph_sel = fields[s].units_glyph;
                    on_digit  = 1'b1;
                end
            end
        end else if (beam_q.char_row == ROW_DATE) begin
            for (int s = int'(SLOT_DAY); s <= int'(SLOT_YEAR); s++) begin
                if (in_cell(beam_q.char_col, FIELD_COL[s])) begin
                    glyph_sel = fields[s].tens_glyph;
                    on_digit  = 1'b1;
                end
                if (in_cell(beam_q.char_col, FIELD_COL[s] + DIGIT_COLS)) begin
                    glyph_sel = fields[s].units_glyph;
                    on_digit  = 1'b1;
                end
            end
            if (in_cell(beam_q.char_col, COL_YEAR_PREFIX)) begin
                glyph_sel = PREFIX_TENS;
                on_digit  = 1'b1;
            end
            if (in_cell(beam_q.char_col, COL_YEAR_PREFIX + DIGIT_COLS)) begin
                glyph_sel = PREFIX_UNITS;
                on_digit  = 1'b1;
            end
        end
    end

    // stage 2 puts the glyph code on top and the pixel row inside the glyph below
    always_ff @(posedge reloj) begin
        if (resetM) begin
            font_addr <= '0;
        end else if (on_digit) begin
            font_addr <= {glyph_sel, beam_q.pixel_row};
        end else begin
            font_addr <= '0;
        end
    end

endmodule

// File: rtl/field_slot.sv
module field_slot (
    input  logic                           reloj,
    input  logic                           resetM,
    input  logic                           load,
    input  clock_field_pkg::digit_pair_t   digits,
    output clock_field_pkg::field_glyphs_t glyphs
);
    import clock_field_pkg::*;

    digit_pair_t held;

    // each digit maps to a font code and anything that is not BCD shows as an empty cell
    function automatic glyph_t to_glyph(input bcd_digit_t d);
        if (d == 4'd0) begin
            return GLYPH_ZERO;
        end else if (d <= 4'd9) begin
            return glyph_t'(d);
        end
        return GLYPH_BLANK;
    endfunction

    always_ff @(posedge reloj) begin
        if (resetM) begin
            held <= '0;
        end else if (load) begin
            held <= digits;
        end
    end

    assign glyphs.tens_glyph  = to_glyph(held.tens);
    assign glyphs.units_glyph = to_glyph(held.units);

    // the font has nothing above the zero glyph
    a_glyph_range: assert property (
        @(posedge reloj) disable iff (resetM)
        (glyphs.tens_glyph <= GLYPH_ZERO) && (glyphs.units_glyph <= GLYPH_ZERO)
    );

endmodule

// File: rtl/digit_loader.sv
module digit_loader (
    input  logic                                   reloj,
    input  logic                                   resetM,
    input  logic                                   wr_strobe,
    input  clock_field_pkg::digit_write_t          wr_req,
    output logic [clock_field_pkg::NUM_FIELDS-1:0] load_en,
    output clock_field_pkg::digit_pair_t           digits_q
);
    import clock_field_pkg::*;

    logic [NUM_FIELDS-1:0] load_next;

    // the field code picks a slot position and unknown codes select nothing
    always_comb begin
        load_next = '0;
        if (wr_strobe) begin
            case (wr_req.field)
                FIELD_HOUR:          load_next[SLOT_HOUR]          = 1'b1;
                FIELD_MINUTE:        load_next[SLOT_MINUTE]        = 1'b1;
                FIELD_SECOND:        load_next[SLOT_SECOND]        = 1'b1;
                FIELD_CHRONO_HOUR:   load_next[SLOT_CHRONO_HOUR]   = 1'b1;
                FIELD_CHRONO_MINUTE: load_next[SLOT_CHRONO_MINUTE] = 1'b1;
                FIELD_CHRONO_SECOND: load_next[SLOT_CHRONO_SECOND] = 1'b1;
                FIELD_DAY:           load_next[SLOT_DAY]           = 1'b1;
                FIELD_MONTH:         load_next[SLOT_MONTH]         = 1'b1;
                FIELD_YEAR:          load_next[SLOT_YEAR]          = 1'b1;
                default:             load_next                     = '0;
            endcase
        end
    end

    always_ff @(posedge reloj) begin
        if (resetM) begin
            load_en <= '0;
        end else begin
            load_en <= load_next;
        end
    end

    // the digit pair lines up with the strobe it belongs to
    always_ff @(posedge reloj) begin
        if (wr_strobe) begin
            digits_q.tens  <= wr_req.tens;
            digits_q.units <= wr_req.units;
        end
    end

    // at most one slot may take the shared digit pair in any cycle
    a_load_onehot: assert property (
        @(posedge reloj) disable iff (resetM)
        $onehot0(load_en)
    );

endmodule

// File: rtl/screen_layout_pkg.sv
package screen_layout_pkg;

    typedef logic [5:0] char_row_t;
    typedef logic [6:0] char_col_t;
    typedef logic [3:0] pixel_row_t;
    typedef logic [7:0] font_addr_t;

    typedef struct packed {
        char_row_t  char_row;
        char_col_t  char_col;
        pixel_row_t pixel_row;
    } beam_pos_t;

    typedef struct packed {
        logic       time_en;
        logic       date_en;
        logic       chrono_en;
        logic [1:0] time_ptr;
        logic [1:0] date_ptr;
        logic [1:0] chrono_ptr;
    } edit_ctrl_t;

    // character rows of the two bands
    localparam char_row_t ROW_TIME = 6'd12;
    localparam char_row_t ROW_DATE = 6'd17;

    // each digit is two character columns wide
    localparam char_col_t DIGIT_COLS = 7'd2;

    // left column of the tens digit with the units digit DIGIT_COLS further right
    localparam char_col_t COL_HOUR          = 7'd10;
    localparam char_col_t COL_MINUTE        = 7'd16;
    localparam char_col_t COL_SECOND        = 7'd22;
    localparam char_col_t COL_CHRONO_HOUR   = 7'd66;
    localparam char_col_t COL_CHRONO_MINUTE = 7'd72;
    localparam char_col_t COL_CHRONO_SECOND = 7'd78;
    localparam char_col_t COL_DAY           = 7'd34;
    localparam char_col_t COL_MONTH         = 7'd42;
    localparam char_col_t COL_YEAR_PREFIX   = 7'd48;
    localparam char_col_t COL_YEAR          = 7'd52;

    // same columns indexed by slot position
    localparam char_col_t FIELD_COL [clock_field_pkg::NUM_FIELDS] = '{
        COL_HOUR, COL_MINUTE, COL_SECOND,
        COL_CHRONO_HOUR, COL_CHRONO_MINUTE, COL_CHRONO_SECOND,
        COL_DAY, COL_MONTH, COL_YEAR
    };

endpackage

// File: rtl/clock_field_pkg.sv
package clock_field_pkg;

    // number of two-digit fields on the display
    localparam int NUM_FIELDS = 9;

    // field codes as the host sends them
    typedef enum logic [3:0] {
        FIELD_DAY           = 4'd0,
        FIELD_MONTH         = 4'd1,
        FIELD_YEAR          = 4'd2,
        FIELD_SECOND        = 4'd3,
        FIELD_MINUTE        = 4'd4,
        FIELD_HOUR          = 4'd5,
        FIELD_CHRONO_SECOND = 4'd6,
        FIELD_CHRONO_MINUTE = 4'd7,
        FIELD_CHRONO_HOUR   = 4'd8
    } field_code_t;

    // slot positions in display order, left to right and top band first
    typedef enum logic [3:0] {
        SLOT_HOUR          = 4'd0,
        SLOT_MINUTE        = 4'd1,
        SLOT_SECOND        = 4'd2,
        SLOT_CHRONO_HOUR   = 4'd3,
        SLOT_CHRONO_MINUTE = 4'd4,
        SLOT_CHRONO_SECOND = 4'd5,
        SLOT_DAY           = 4'd6,
        SLOT_MONTH         = 4'd7,
        SLOT_YEAR          = 4'd8
    } slot_index_t;

    typedef logic [3:0] bcd_digit_t;
    typedef logic [3:0] glyph_t;

    // the font keeps zero at code 10, code 0 is an empty cell
    localparam glyph_t GLYPH_ZERO  = 4'd10;
    localparam glyph_t GLYPH_BLANK = 4'd0;

    typedef struct packed {
        field_code_t field;
        bcd_digit_t  tens;
        bcd_digit_t  units;
    } digit_write_t;

    typedef struct packed {
        bcd_digit_t tens;
        bcd_digit_t units;
    } digit_pair_t;

    typedef struct packed {
        glyph_t tens_glyph;
        glyph_t units_glyph;
    } field_glyphs_t;

endpackage
